// File: src/glbPkg.sv
/*
 * Global buffer package
 * Sizes, vector types, configuration structs and port state shared by the buffer
 */
`default_nettype none

package glbPkg;

    // ==========================================================================
    // Sizes
    // ==========================================================================
    localparam int NumBank   = 4;
    localparam int BankWords = 16;
    localparam int WordBits  = $clog2(BankWords);
    localparam int NumWrPort = 2;
    localparam int NumRdPort = 2;
    // Write ports first, then read ports
    localparam int NumPort   = NumWrPort + NumRdPort;

    // ==========================================================================
    // Vector types
    // ==========================================================================
    typedef logic [31:0] dataT;
    typedef logic [5:0]  addrT;
    typedef logic [3:0]  wordT;
    typedef logic [1:0]  bankIdxT;
    typedef logic [3:0]  loopT;
    typedef logic        portSelT;

    // ==========================================================================
    // Configuration structs
    // ==========================================================================
    typedef struct packed {
        addrT addrMax;
        loopT loopMax;
    } portCfgT;

    // One write port and one read port per bank, indexed by bank number
    typedef struct packed {
        portSelT [NumBank-1:0] wrPort;
        portSelT [NumBank-1:0] rdPort;
    } bankMapT;

    // Position of each bank among the banks of its own port
    typedef struct packed {
        bankIdxT [NumBank-1:0] wrRel;
        bankIdxT [NumBank-1:0] rdRel;
    } bankRouteT;

    typedef enum logic {
        Idle,
        Work
    } portStateT;

endpackage

`default_nettype wire

// File: src/glbBank.sv
/*
 * Buffer bank
 * Sixteen words with one write or one registered read per cycle
 */
`default_nettype none

module glbBank (
    input  logic         clk,
    input  logic         we,
    input  glbPkg::wordT wordIdx,
    input  glbPkg::dataT wrData,
    input  logic         re,
    input  glbPkg::wordT rdIdx,
    output glbPkg::dataT rdData
);
    import glbPkg::*;

    dataT mem [BankWords];

    // ==========================================================================
    // Storage
    // ==========================================================================
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wordIdx] <= wrData;
        end
    end

    // Read data held until the next read
    always_ff @(posedge clk) begin
        if (re) begin
            rdData <= mem[rdIdx];
        end
    end

    // Arbitration upstream keeps one access per cycle
    oneAccess: assert property (@(posedge clk) !(we && re));

endmodule

`default_nettype wire

// File: src/glbBankMap.sv
/*
 * Bank map register
 * Holds the bank to port map and derives each bank's relative index in its ports
 */
`default_nettype none

module glbBankMap (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [glbPkg::NumPort-1:0] cfgVld,
    input  glbPkg::bankMapT            bankMap,
    output glbPkg::bankMapT            map,
    output glbPkg::bankRouteT          route
);
    import glbPkg::*;

    // Any port configuration reloads the whole map
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            map <= '0;
        end else if (|cfgVld) begin
            map <= bankMap;
        end
    end

    // ==========================================================================
    // Relative index
    // ==========================================================================
    // Count earlier banks on the same port, lowest bank sits at the bottom
    always_comb begin
        route = '0;
        for (int b = 0; b < NumBank; b++) begin
            for (int e = 0; e < b; e++) begin
                if (map.wrPort[e] == map.wrPort[b]) begin
                    route.wrRel[b] = route.wrRel[b] + 2'd1;
                end
                if (map.rdPort[e] == map.rdPort[b]) begin
                    route.rdRel[b] = route.rdRel[b] + 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: src/glbPortSeq.sv
/*
 * Port sequencer
 * Address and loop counters of one port, with its active state and done pulse
 */
`default_nettype none

module glbPortSeq (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            cfgVld,
    input  glbPkg::portCfgT cfg,
    input  logic            access,
    output logic            active,
    output glbPkg::addrT    addr,
    output logic            done
);
    import glbPkg::*;

    portStateT state;
    portCfgT   cfgReg;
    loopT      loopCnt;
    logic      lastAddr;
    logic      lastLoop;

    assign active   = (state == Work);
    assign lastAddr = (addr == cfgReg.addrMax);
    assign lastLoop = (loopCnt == cfgReg.loopMax);

    // ==========================================================================
    // State and counters
    // ==========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= Idle;
            cfgReg  <= '0;
            addr    <= '0;
            loopCnt <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            // A new configuration restarts the walk even in the middle of one
            if (cfgVld) begin
                state   <= Work;
                cfgReg  <= cfg;
                addr    <= '0;
                loopCnt <= '0;
            end else if (access) begin
                if (lastAddr) begin
                    addr <= '0;
                    if (lastLoop) begin
                        state   <= Idle;
                        loopCnt <= '0;
                        done    <= 1'b1;
                    end else begin
                        loopCnt <= loopCnt + 4'd1;
                    end
                end else begin
                    addr <= addr + 6'd1;
                end
            end
        end
    end

    // The bank array only grants accesses to ports that are working
    accessWhileIdle: assert property (@(posedge clk) disable iff (!rst_n) access |-> active);

endmodule

`default_nettype wire

// File: src/glbBankArray.sv
/*
 * Bank array
 * Decodes port addresses to banks, gives reads priority and steers data
 */
`default_nettype none

module glbBankArray (
    input  logic                         clk,
    input  logic                         rst_n,
    input  glbPkg::bankMapT              map,
    input  glbPkg::bankRouteT            route,
    input  logic [glbPkg::NumWrPort-1:0] wrActive,
    input  glbPkg::addrT                 wrAddr [glbPkg::NumWrPort],
    input  logic [glbPkg::NumRdPort-1:0] rdActive,
    input  glbPkg::addrT                 rdAddr [glbPkg::NumRdPort],
    input  logic [glbPkg::NumWrPort-1:0] wrVld,
    input  glbPkg::dataT                 wrDat [glbPkg::NumWrPort],
    input  logic [glbPkg::NumRdPort-1:0] rdRdy,
    output logic [glbPkg::NumWrPort-1:0] wrRdy,
    output logic [glbPkg::NumWrPort-1:0] wrAccess,
    output logic [glbPkg::NumRdPort-1:0] rdAccess,
    output glbPkg::dataT                 rdDat [glbPkg::NumRdPort],
    output logic [glbPkg::NumRdPort-1:0] rdVld
);
    import glbPkg::*;

    logic [NumBank-1:0] rdHit;
    logic [NumBank-1:0] wrHit;
    logic [NumBank-1:0] wrBanks [NumWrPort];
    logic [NumBank-1:0] rdBanks [NumRdPort];
    dataT               bankRdData [NumBank];
    bankIdxT            rdSelD [NumRdPort];
    bankIdxT            rdSelQ [NumRdPort];

    function automatic bankIdxT relBank(addrT a);
        return bankIdxT'(a >> WordBits);
    endfunction

    function automatic wordT wordOf(addrT a);
        return wordT'(a);
    endfunction

    // ==========================================================================
    // Per bank decode and arbitration
    // ==========================================================================
    for (genvar b = 0; b < NumBank; b++) begin : gBank
        portSelT wp;
        portSelT rp;

        assign wp = map.wrPort[b];
        assign rp = map.rdPort[b];
        assign rdHit[b] = rdActive[rp] && rdRdy[rp] && (relBank(rdAddr[rp]) == route.rdRel[b]);
        // Write waits whenever this bank serves a read
        assign wrHit[b] = wrActive[wp] && wrVld[wp] && !rdHit[b]
                          && (relBank(wrAddr[wp]) == route.wrRel[b]);

        glbBank Ubank (
            .clk     (clk),
            .we      (wrHit[b]),
            .wordIdx (wordOf(wrAddr[wp])),
            .wrData  (wrDat[wp]),
            .re      (rdHit[b]),
            .rdIdx   (wordOf(rdAddr[rp])),
            .rdData  (bankRdData[b])
        );
    end

    // Gather the banks each port hits this cycle
    always_comb begin
        for (int p = 0; p < NumWrPort; p++) begin
            for (int b = 0; b < NumBank; b++) begin
                wrBanks[p][b] = wrHit[b] && (map.wrPort[b] == portSelT'(p));
            end
        end
        for (int r = 0; r < NumRdPort; r++) begin
            rdSelD[r] = '0;
            for (int b = 0; b < NumBank; b++) begin
                rdBanks[r][b] = rdHit[b] && (map.rdPort[b] == portSelT'(r));
                if (rdBanks[r][b]) begin
                    rdSelD[r] = bankIdxT'(b);
                end
            end
        end
    end

    // ==========================================================================
    // Port strobes and read return
    // ==========================================================================
    for (genvar p = 0; p < NumWrPort; p++) begin : gWrPort
        assign wrRdy[p]    = |wrBanks[p];
        assign wrAccess[p] = wrRdy[p];
        wrOneBank: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(wrBanks[p]));
    end

    for (genvar r = 0; r < NumRdPort; r++) begin : gRdPort
        assign rdAccess[r] = |rdBanks[r];
        // Bank data is already registered, only the choice is held here
        assign rdDat[r]    = bankRdData[rdSelQ[r]];
        rdOneBank: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(rdBanks[r]));
    end

    always_ff @(posedge clk) begin
        for (int r = 0; r < NumRdPort; r++) begin
            rdSelQ[r] <= rdSelD[r];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdVld <= '0;
        end else begin
            rdVld <= rdAccess;
        end
    end

endmodule

`default_nettype wire

// File: src/glbTop.sv
/*
 * Global buffer top level
 * Four banks shared by two write ports and two read ports under a bank map
 */
`default_nettype none

module glbTop (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [glbPkg::NumPort-1:0]   cfgVld,
    input  glbPkg::portCfgT              cfgPort [glbPkg::NumPort],
    input  glbPkg::bankMapT              bankMap,
    output logic [glbPkg::NumPort-1:0]   cfgRdy,
    input  logic [glbPkg::NumWrPort-1:0] wrVld,
    input  glbPkg::dataT                 wrDat [glbPkg::NumWrPort],
    output logic [glbPkg::NumWrPort-1:0] wrRdy,
    input  logic [glbPkg::NumRdPort-1:0] rdRdy,
    output glbPkg::dataT                 rdDat [glbPkg::NumRdPort],
    output logic [glbPkg::NumRdPort-1:0] rdVld
);
    import glbPkg::*;

    bankMapT                map;
    bankRouteT              route;
    logic [NumWrPort-1:0]   wrActive;
    logic [NumWrPort-1:0]   wrAccess;
    addrT                   wrAddr [NumWrPort];
    logic [NumRdPort-1:0]   rdActive;
    logic [NumRdPort-1:0]   rdAccess;
    addrT                   rdAddr [NumRdPort];

    glbBankMap UbankMap (
        .clk     (clk),
        .rst_n   (rst_n),
        .cfgVld  (cfgVld),
        .bankMap (bankMap),
        .map     (map),
        .route   (route)
    );

    // ==========================================================================
    // Port sequencers
    // ==========================================================================
    glbPortSeq UwrSeq0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .cfgVld (cfgVld[0]),
        .cfg    (cfgPort[0]),
        .access (wrAccess[0]),
        .active (wrActive[0]),
        .addr   (wrAddr[0]),
        .done   (cfgRdy[0])
    );

    glbPortSeq UwrSeq1 (
        .clk    (clk),
        .rst_n  (rst_n),
        .cfgVld (cfgVld[1]),
        .cfg    (cfgPort[1]),
        .access (wrAccess[1]),
        .active (wrActive[1]),
        .addr   (wrAddr[1]),
        .done   (cfgRdy[1])
    );

    glbPortSeq UrdSeq0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .cfgVld (cfgVld[NumWrPort]),
        .cfg    (cfgPort[NumWrPort]),
        .access (rdAccess[0]),
        .active (rdActive[0]),
        .addr   (rdAddr[0]),
        .done   (cfgRdy[NumWrPort])
    );

    glbPortSeq UrdSeq1 (
        .clk    (clk),
        .rst_n  (rst_n),
        .cfgVld (cfgVld[NumWrPort+1]),
        .cfg    (cfgPort[NumWrPort+1]),
        .access (rdAccess[1]),
        .active (rdActive[1]),
        .addr   (rdAddr[1]),
        .done   (cfgRdy[NumWrPort+1])
    );

    glbBankArray UbankArray (
        .clk      (clk),
        .rst_n    (rst_n),
        .map      (map),
        .route    (route),
        .wrActive (wrActive),
        .wrAddr   (wrAddr),
        .rdActive (rdActive),
        .rdAddr   (rdAddr),
        .wrVld    (wrVld),
        .wrDat    (wrDat),
        .rdRdy    (rdRdy),
        .wrRdy    (wrRdy),
        .wrAccess (wrAccess),
        .rdAccess (rdAccess),
        .rdDat    (rdDat),
        .rdVld    (rdVld)
    );

endmodule

`default_nettype wire

// File: tb/glbTests.svh
/*
 * Directed tests of the global buffer
 * Each task drives the DUT through the cycle checker
 */

    // Strobes low after reset, idle ports ignore valid and ready
    task automatic checkResetState();
        @(negedge clk);
        for (int p = 0; p < NumWrPort; p++) begin
            checkBit($sformatf("wrRdy[%0d]", p), 1'b0, wrRdy[p]);
        end
        for (int r = 0; r < NumRdPort; r++) begin
            checkBit($sformatf("rdVld[%0d]", r), 1'b0, rdVld[r]);
        end
        for (int p = 0; p < NumPort; p++) begin
            checkBit($sformatf("cfgRdy[%0d]", p), 1'b0, cfgRdy[p]);
        end
        repeat (2) stepCycle('0, '1, '1);
    endtask

    // ==========================================================================
    // Data path
    // ==========================================================================
    task automatic writeReadBack();
        // Banks 0 and 2 on port 0, banks 1 and 3 on port 1
        mapNext.wrPort = 4'b1010;
        mapNext.rdPort = 4'b1010;
        cfgNext[0] = '{addrMax: 6'd31, loopMax: 4'd0};
        stepCycle(4'b0001, '0, '0);
        runPorts(2'b01, 2'b00, 1'b0);
        cfgNext[NumWrPort] = '{addrMax: 6'd31, loopMax: 4'd0};
        stepCycle(4'b0100, '0, '0);
        runPorts(2'b00, 2'b01, 1'b0);
    endtask

    task automatic dualPortRun();
        cfgNext[0] = '{addrMax: 6'd31, loopMax: 4'd0};
        cfgNext[1] = '{addrMax: 6'd31, loopMax: 4'd0};
        stepCycle(4'b0011, '0, '0);
        runPorts(2'b11, 2'b00, 1'b1);
        cfgNext[NumWrPort]   = '{addrMax: 6'd31, loopMax: 4'd0};
        cfgNext[NumWrPort+1] = '{addrMax: 6'd31, loopMax: 4'd0};
        stepCycle(4'b1100, '0, '0);
        runPorts(2'b00, 2'b11, 1'b1);
        // Write port 1 refills its banks while read port 0 drains the others
        stepCycle(4'b0110, '0, '0);
        runPorts(2'b10, 2'b01, 1'b1);
    endtask

    // ==========================================================================
    // Sequencing and arbitration
    // ==========================================================================
    task automatic loopDone();
        int expCount;
        expCount      = (5 + 1) * (2 + 1);
        wrAccepted[1] = 0;
        cfgNext[1]    = '{addrMax: 6'd5, loopMax: 4'd2};
        stepCycle(4'b0010, '0, '0);
        runPorts(2'b10, 2'b00, 1'b0);
        // Valid stays high after the done pulse
        repeat (4) stepCycle('0, 2'b10, '0);
        if (wrAccepted[1] != expCount) begin
            $display("write port 1 accepted %0d words instead of %0d", wrAccepted[1], expCount);
            otherCount++;
        end
    endtask

    task automatic readPriority();
        cfgNext[0]         = '{addrMax: 6'd0, loopMax: 4'd0};
        cfgNext[NumWrPort] = '{addrMax: 6'd0, loopMax: 4'd1};
        stepCycle(4'b0101, '0, '0);
        // Read and write both aim at word 0 of bank 0
        stepCycle('0, 2'b01, 2'b01);
        stepCycle('0, 2'b01, 2'b00);
        runPorts(2'b01, 2'b01, 1'b0);
    endtask

    task automatic restartPort();
        cfgNext[NumWrPort] = '{addrMax: 6'd31, loopMax: 4'd0};
        stepCycle(4'b0100, '0, '0);
        repeat (5) stepCycle('0, '0, 2'b01);
        // New configuration in the middle of the walk
        stepCycle(4'b0100, '0, 2'b01);
        runPorts(2'b00, 2'b01, 1'b0);
    endtask

// File: tb/glbTb.sv
/*
 * Global buffer testbench
 * Clock, reset, DUT, model memory, cycle checker and watchdog
 */
`default_nettype none

module glbTb;
    import glbPkg::*;

    // Rough length of all tests together, stalls included
    localparam int TestCycles    = 400;
    localparam int TimeoutCycles = 5 * TestCycles;

    logic                 clk;
    logic                 rst_n;
    logic [NumPort-1:0]   cfgVld;
    portCfgT              cfgPort [NumPort];
    bankMapT              bankMap;
    logic [NumPort-1:0]   cfgRdy;
    logic [NumWrPort-1:0] wrVld;
    dataT                 wrDat [NumWrPort];
    logic [NumWrPort-1:0] wrRdy;
    logic [NumRdPort-1:0] rdRdy;
    dataT                 rdDat [NumRdPort];
    logic [NumRdPort-1:0] rdVld;

    // ==========================================================================
    // Model state, indexed write ports first, then read ports
    // ==========================================================================
    dataT                 modelMem [NumBank][BankWords];
    bankMapT              mapNext;
    bankMapT              mapM;
    portCfgT              cfgNext [NumPort];
    int                   left [NumPort];
    addrT                 addrM [NumPort];
    addrT                 maxM [NumPort];
    int                   wrAccepted [NumWrPort];
    logic [NumRdPort-1:0] rdPend;
    dataT                 rdExp [NumRdPort];
    logic [NumPort-1:0]   doneExp;
    int                   mismatchCount;
    int                   otherCount;

    glbTop UUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .cfgVld  (cfgVld),
        .cfgPort (cfgPort),
        .bankMap (bankMap),
        .cfgRdy  (cfgRdy),
        .wrVld   (wrVld),
        .wrDat   (wrDat),
        .wrRdy   (wrRdy),
        .rdRdy   (rdRdy),
        .rdDat   (rdDat),
        .rdVld   (rdVld)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic checkBit(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("mismatch at %0t: %s expected %b, got %b", $time, name, exp, act);
            mismatchCount++;
        end
    endtask

    task automatic checkData(string name, dataT exp, dataT act);
        if (act !== exp) begin
            $display("mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
            mismatchCount++;
        end
    endtask

    // Target bank of a linear address, lowest mapped bank at the bottom
    function automatic int bankOf(logic isRd, int port, addrT a);
        int      rel;
        int      seen;
        int      found;
        portSelT owner;
        rel   = int'(a) / BankWords;
        seen  = 0;
        found = 0;
        for (int b = 0; b < NumBank; b++) begin
            owner = isRd ? mapM.rdPort[b] : mapM.wrPort[b];
            if (owner == portSelT'(port)) begin
                if (seen == rel) begin
                    found = b;
                end
                seen++;
            end
        end
        return found;
    endfunction

    // Wrap at addrMax, true on the last access of the walk
    function automatic logic advancePort(int i);
        addrM[i] = (addrM[i] == maxM[i]) ? '0 : addrM[i] + 6'd1;
        left[i]  = left[i] - 1;
        return left[i] == 0;
    endfunction

    // ==========================================================================
    // One clock cycle of stimulus and checking
    // ==========================================================================
    task automatic stepCycle(logic [NumPort-1:0] cfgMask, logic [NumWrPort-1:0] wrMask,
                             logic [NumRdPort-1:0] rdMask);
        logic [NumWrPort-1:0] wrGo;
        logic [NumRdPort-1:0] rdGo;
        logic [NumPort-1:0]   doneNow;
        logic                 wrExp;
        dataT                 datNow [NumWrPort];
        int                   rdBank [NumRdPort];
        int                   wb;
        int                   i;
        wrGo = wrMask & ~cfgMask[NumWrPort-1:0];
        rdGo = rdMask & ~cfgMask[NumPort-1:NumWrPort];
        @(posedge clk);
        cfgVld  <= cfgMask;
        bankMap <= mapNext;
        wrVld   <= wrGo;
        rdRdy   <= rdGo;
        for (int p = 0; p < NumPort; p++) begin
            cfgPort[p] <= cfgNext[p];
        end
        for (int p = 0; p < NumWrPort; p++) begin
            datNow[p] = $urandom;
            wrDat[p] <= datNow[p];
        end
        @(negedge clk);
        // Registered outputs of the previous cycle
        for (int r = 0; r < NumRdPort; r++) begin
            checkBit($sformatf("rdVld[%0d]", r), rdPend[r], rdVld[r]);
            if (rdPend[r]) begin
                checkData($sformatf("rdDat[%0d]", r), rdExp[r], rdDat[r]);
            end
        end
        for (int p = 0; p < NumPort; p++) begin
            checkBit($sformatf("cfgRdy[%0d]", p), doneExp[p], cfgRdy[p]);
        end
        doneNow = '0;
        // Reads go first and block writes to their banks
        for (int r = 0; r < NumRdPort; r++) begin
            i         = NumWrPort + r;
            rdPend[r] = rdGo[r] && (left[i] > 0);
            rdBank[r] = bankOf(1'b1, r, addrM[i]);
            if (rdPend[r]) begin
                rdExp[r]   = modelMem[rdBank[r]][int'(addrM[i]) % BankWords];
                doneNow[i] = advancePort(i);
            end
        end
        for (int p = 0; p < NumWrPort; p++) begin
            wb    = bankOf(1'b0, p, addrM[p]);
            wrExp = wrGo[p] && (left[p] > 0);
            for (int r = 0; r < NumRdPort; r++) begin
                if (rdPend[r] && (rdBank[r] == wb)) begin
                    wrExp = 1'b0;
                end
            end
            checkBit($sformatf("wrRdy[%0d]", p), wrExp, wrRdy[p]);
            if (wrGo[p] && wrRdy[p]) begin
                wrAccepted[p]++;
            end
            if (wrExp) begin
                modelMem[wb][int'(addrM[p]) % BankWords] = datNow[p];
                doneNow[p] = advancePort(p);
            end
        end
        // New configuration counts from the next cycle on
        for (int p = 0; p < NumPort; p++) begin
            if (cfgMask[p]) begin
                left[p]  = (int'(cfgNext[p].addrMax) + 1) * (int'(cfgNext[p].loopMax) + 1);
                addrM[p] = '0;
                maxM[p]  = cfgNext[p].addrMax;
            end
        end
        if (|cfgMask) begin
            mapM = mapNext;
        end
        doneExp = doneNow;
    endtask

    function automatic logic busy(logic [NumWrPort-1:0] wrMask, logic [NumRdPort-1:0] rdMask);
        logic pending;
        pending = (|rdPend) || (|doneExp);
        for (int p = 0; p < NumWrPort; p++) begin
            if (wrMask[p] && (left[p] > 0)) begin
                pending = 1'b1;
            end
        end
        for (int r = 0; r < NumRdPort; r++) begin
            if (rdMask[r] && (left[NumWrPort+r] > 0)) begin
                pending = 1'b1;
            end
        end
        return pending;
    endfunction

    // Run the given ports until their walks, reads and done pulses are over
    task automatic runPorts(logic [NumWrPort-1:0] wrMask, logic [NumRdPort-1:0] rdMask,
                            logic stall);
        logic [NumWrPort-1:0] wrGo;
        logic [NumRdPort-1:0] rdGo;
        while (busy(wrMask, rdMask)) begin
            wrGo = wrMask;
            rdGo = rdMask;
            if (stall) begin
                wrGo = wrMask & NumWrPort'($urandom);
                rdGo = rdMask & NumRdPort'($urandom);
            end
            stepCycle('0, wrGo, rdGo);
        end
    endtask

    `include "glbTests.svh"

    initial begin
        void'($urandom(32'h2dcd6b6c));
        mismatchCount = 0;
        otherCount    = 0;
        rdPend        = '0;
        doneExp       = '0;
        mapM          = '0;
        mapNext       = '0;
        for (int p = 0; p < NumPort; p++) begin
            left[p]    = 0;
            addrM[p]   = '0;
            maxM[p]    = '0;
            cfgNext[p] = '0;
            cfgPort[p] = '0;
        end
        for (int p = 0; p < NumWrPort; p++) begin
            wrAccepted[p] = 0;
            wrDat[p]      = '0;
        end
        cfgVld  = '0;
        bankMap = '0;
        wrVld   = '0;
        rdRdy   = '0;
        rst_n   = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        checkResetState();
        writeReadBack();
        dualPortRun();
        loopDone();
        readPriority();
        restartPort();

        $display("errors: %0d mismatches, %0d other", mismatchCount, otherCount);
        if (mismatchCount + otherCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        repeat (TimeoutCycles) @(posedge clk);
        $display("timeout: tests still running after %0d cycles", TimeoutCycles);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+tb
src/glbPkg.sv
src/glbBank.sv
src/glbBankMap.sv
src/glbPortSeq.sv
src/glbBankArray.sv
src/glbTop.sv
tb/glbTb.sv

// File: Makefile
# Verilator build and run of the global buffer testbench

VERILATOR ?= verilator
TOP       ?= glbTb
FLIST     ?= src.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS      ?= test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

# Pass only when the pass line shows up in the output
run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf $(OBJDIR)
